// File: hdl/load_pkg.sv
// --------------------
// load unit package
// shared widths, the load operation encoding, the two views of a
// returned cache word and the cache transfer-size mapping
// --------------------

package load_pkg;

    // --------------------
    // widths
    // --------------------
    // register and data-cache word width
    localparam int unsigned XLEN = 64;
    // sv39 virtual address and the physical address behind it
    localparam int unsigned VLEN = 39;
    localparam int unsigned PLEN = 56;
    // a 4 KiB page leaves the low 12 address bits untranslated
    localparam int unsigned PAGE_OFFSET_WIDTH = 12;
    // the cache is indexed inside the page offset, so the index is ready
    // before translation and only the tag waits for the TLB
    localparam int unsigned DCACHE_INDEX_WIDTH = PAGE_OFFSET_WIDTH;
    // everything above the index is tag, 44 bits for a 56-bit physical address
    localparam int unsigned DCACHE_TAG_WIDTH = PLEN - DCACHE_INDEX_WIDTH;
    // scoreboard transaction id
    localparam int unsigned TRANS_ID_BITS = 3;
    // bytes in one data word
    localparam int unsigned NUM_BYTES = XLEN / 8;

    // --------------------
    // load operations
    // --------------------
    // integer loads of rv64, the U variants zero-extend
    typedef enum logic [3:0] {
        LD  = 4'd0,
        LW  = 4'd1,
        LWU = 4'd2,
        LH  = 4'd3,
        LHU = 4'd4,
        LB  = 4'd5,
        LBU = 4'd6
    } load_op_e;

    // the returned word is shifted as a whole, while the sign candidates
    // are the top bits of the single bytes
    typedef union packed {
        logic [XLEN-1:0]           word;
        logic [NUM_BYTES-1:0][7:0] bytes;
    } load_word_u;

    // cache size code is log2 of the access width in bytes
    function automatic logic [1:0] transfer_size_of(input load_op_e op);
        logic [1:0] size;
        unique case (op)
            LD: begin
                size = 2'd3;
            end
            LW, LWU: begin
                size = 2'd2;
            end
            LH, LHU: begin
                size = 2'd1;
            end
            default: begin
                // byte loads and any unused encoding
                size = 2'd0;
            end
        endcase
        return size;
    endfunction

endpackage

// File: hdl/load_ctrl_fsm.sv
// --------------------
// load request control
// runs the cache request and tag handshake against the TLB and the
// store address checker, keeps the popped transaction and flags the
// response that may retire
// --------------------

`timescale 1ns/100ps

module load_ctrl_fsm import load_pkg::*; (
    input  logic                     clk_i,
    input  logic                     rst_ni,
    input  logic                     flush_i,
    // load from the issue side, held until pop_ld_o
    input  logic                     valid_i,
    input  logic [TRANS_ID_BITS-1:0] trans_id_i,
    input  logic [2:0]               offset_i,
    input  load_op_e                 op_i,
    input  logic [7:0]               be_i,
    output logic                     pop_ld_o,
    // translation and store-address check
    input  logic                     page_offset_matches_i,
    input  logic                     dtlb_hit_i,
    output logic                     translation_req_o,
    // data-cache request side
    output logic                     data_req_o,
    input  logic                     data_gnt_i,
    output logic                     tag_valid_o,
    output logic                     kill_req_o,
    output logic [7:0]               data_be_o,
    output logic [1:0]               data_size_o,
    // data-cache response side
    input  logic                     data_rvalid_i,
    output logic                     valid_o,
    output logic [TRANS_ID_BITS-1:0] trans_id_o,
    output load_op_e                 op_q_o,
    output logic [2:0]               offset_q_o
);

    enum logic [2:0] {
        IDLE,
        WAIT_GNT,
        SEND_TAG,
        WAIT_PAGE_OFFSET,
        ABORT_TRANSACTION,
        WAIT_TRANSLATION,
        WAIT_FLUSH
    } state_d, state_q;

    // transaction that is in flight towards the response
    logic [TRANS_ID_BITS-1:0] trans_id_q;
    logic [2:0]               offset_q;
    load_op_e                 op_q;

    // byte enables and size come straight from the load being issued
    assign data_be_o   = be_i;
    assign data_size_o = transfer_size_of(op_i);

    // --------------------
    // load control
    // --------------------
    always_comb begin : p_load_control
        state_d           = state_q;
        translation_req_o = 1'b0;
        data_req_o        = 1'b0;
        tag_valid_o       = 1'b0;
        kill_req_o        = 1'b0;
        pop_ld_o          = 1'b0;

        unique case (state_q)
            // SEND_TAG finishes the previous load and can start the next one
            // in the same cycle, so it shares the request path with IDLE
            IDLE, SEND_TAG: begin
                tag_valid_o = (state_q == SEND_TAG);
                state_d     = IDLE;
                if (valid_i) begin
                    // translation starts before the store check is known, which keeps
                    // the TLB path short
                    translation_req_o = 1'b1;
                    if (page_offset_matches_i) begin
                        // a pending store aliases this page offset, hold the request
                        state_d = WAIT_PAGE_OFFSET;
                    end else begin
                        data_req_o = 1'b1;
                        state_d    = WAIT_GNT;
                    end
                end
            end

            // stay off the cache until the store checker lets go
            WAIT_PAGE_OFFSET: begin
                if (!page_offset_matches_i) begin
                    state_d = WAIT_GNT;
                end
            end

            WAIT_GNT: begin
                // the request stays up until the cache grants it
                translation_req_o = 1'b1;
                data_req_o        = 1'b1;
            end

            // granted on a TLB miss, so free the cache port and let the page
            // walk fill the TLB while the miss is still being requested
            ABORT_TRANSACTION: begin
                translation_req_o = 1'b1;
                kill_req_o        = 1'b1;
                tag_valid_o       = 1'b1;
                state_d           = WAIT_TRANSLATION;
            end

            WAIT_TRANSLATION: begin
                translation_req_o = 1'b1;
                // retry the cache once the translation is there
                if (dtlb_hit_i) begin
                    state_d = WAIT_GNT;
                end
            end

            // the cache drops whatever request it still holds for us
            WAIT_FLUSH: begin
                kill_req_o  = 1'b1;
                tag_valid_o = 1'b1;
                state_d     = IDLE;
            end

            default: begin
                state_d = IDLE;
            end
        endcase

        // a granted request resolves the same way from IDLE, SEND_TAG and WAIT_GNT,
        // a hit sends the tag next cycle and a miss aborts it
        if (data_req_o && data_gnt_i) begin
            if (dtlb_hit_i) begin
                state_d  = SEND_TAG;
                pop_ld_o = 1'b1;
            end else begin
                state_d = ABORT_TRANSACTION;
            end
        end

        // a flush wins over everything and kills the outstanding tag
        if (flush_i) begin
            state_d = WAIT_FLUSH;
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin : p_state
        if (!rst_ni) begin
            state_q <= IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // the popped load is only needed by the response, one cycle or more later
    always_ff @(posedge clk_i) begin : p_trans
        if (pop_ld_o) begin
            trans_id_q <= trans_id_i;
            offset_q   <= offset_i;
            op_q       <= op_i;
        end
    end

    // --------------------
    // retire
    // --------------------
    // a response counts unless its tag is killed or a flush is being drained
    assign valid_o    = data_rvalid_i && !kill_req_o && (state_q != WAIT_FLUSH);
    assign trans_id_o = trans_id_q;
    assign op_q_o     = op_q;
    assign offset_q_o = offset_q;

    // the load only leaves the issue side once the cache and the TLB both agreed
    a_pop_gnt_hit : assert property (@(posedge clk_i) disable iff (!rst_ni)
        pop_ld_o |-> (data_gnt_i && dtlb_hit_i))
        else $error("load popped without grant and TLB hit");

    // a popped load is followed by a live tag unless a flush cut in
    a_pop_tag : assert property (@(posedge clk_i) disable iff (!rst_ni)
        (pop_ld_o && !flush_i) |=> (tag_valid_o && !kill_req_o))
        else $error("popped load got no valid tag cycle");

endmodule

// File: hdl/load_result_align.sv
// --------------------
// load result aligner
// shifts the requested bytes of the cache word down and sign- or
// zero-extends them, with the sign byte picked ahead at pop
// --------------------

`timescale 1ns/100ps

module load_result_align import load_pkg::*; (
    input  logic            clk_i,
    input  logic            rst_ni,
    input  logic            pop_i,
    // load being popped this cycle
    input  load_op_e        op_d_i,
    input  logic [2:0]      offset_d_i,
    // load stored in the FSM
    input  load_op_e        op_q_i,
    input  logic [2:0]      offset_q_i,
    // cache word and its retire strobe
    input  load_word_u      rdata_i,
    input  logic            valid_i,
    output logic [XLEN-1:0] result_o
);

    logic [XLEN-1:0]      shifted_data;
    logic [NUM_BYTES-1:0] sign_bits;
    logic [2:0]           idx_d, idx_q;
    logic                 signed_d, signed_q;
    logic                 sign_bit;

    // bring the first requested byte down to bit 0
    assign shifted_data = rdata_i.word >> {offset_q_i, 3'b000};

    // every byte's msb can be the sign, depending on size and offset
    always_comb begin : p_sign_bits
        for (int i = 0; i < NUM_BYTES; i++) begin
            sign_bits[i] = rdata_i.bytes[i][7];
        end
    end

    // the top byte of the access is known at pop, so the sign select runs
    // next to the shifter instead of after it
    always_comb begin : p_sign_idx
        unique case (op_d_i)
            LW, LWU: idx_d = offset_d_i + 3'd3;
            LH, LHU: idx_d = offset_d_i + 3'd1;
            default: idx_d = offset_d_i;
        endcase
    end

    assign signed_d = op_d_i inside {LW, LH, LB};

    always_ff @(posedge clk_i or negedge rst_ni) begin : p_sign_regs
        if (!rst_ni) begin
            idx_q    <= '0;
            signed_q <= 1'b0;
        end else if (pop_i) begin
            idx_q    <= idx_d;
            signed_q <= signed_d;
        end
    end

    // zero fill for unsigned loads
    assign sign_bit = signed_q & sign_bits[idx_q];

    // --------------------
    // result mux
    // --------------------
    always_comb begin : p_result
        unique case (op_q_i)
            LW, LWU: result_o = {{(XLEN-32){sign_bit}}, shifted_data[31:0]};
            LH, LHU: result_o = {{(XLEN-16){sign_bit}}, shifted_data[15:0]};
            LB, LBU: result_o = {{(XLEN-8){sign_bit}}, shifted_data[7:0]};
            default: result_o = shifted_data;
        endcase
    end

    // the stored offset must keep a word or a half inside the cache word
    a_word_offset : assert property (@(posedge clk_i) disable iff (!rst_ni)
        (valid_i && (op_q_i inside {LW, LWU})) |-> (offset_q_i < 3'd5))
        else $error("word load retired with offset %0d", offset_q_i);

    a_half_offset : assert property (@(posedge clk_i) disable iff (!rst_ni)
        (valid_i && (op_q_i inside {LH, LHU})) |-> (offset_q_i < 3'd7))
        else $error("half load retired with offset %0d", offset_q_i);

endmodule

// File: hdl/load_unit.sv
// --------------------
// load unit
// takes one load at a time through translation and the data cache and
// returns the aligned, extended result with its transaction id
// --------------------

`timescale 1ns/100ps

module load_unit import load_pkg::*; (
    input  logic                          clk_i,
    input  logic                          rst_ni,
    input  logic                          flush_i,
    // load input
    input  logic                          valid_i,
    input  logic [TRANS_ID_BITS-1:0]      trans_id_i,
    input  logic [VLEN-1:0]               vaddr_i,
    input  load_op_e                      op_i,
    input  logic [7:0]                    be_i,
    output logic                          pop_ld_o,
    // load result
    output logic                          valid_o,
    output logic [TRANS_ID_BITS-1:0]      trans_id_o,
    output logic [XLEN-1:0]               result_o,
    // TLB, answering in the same cycle
    output logic                          translation_req_o,
    output logic [VLEN-1:0]               vaddr_o,
    input  logic [PLEN-1:0]               paddr_i,
    input  logic                          dtlb_hit_i,
    // store address checker
    input  logic                          page_offset_matches_i,
    // data cache
    output logic                          data_req_o,
    input  logic                          data_gnt_i,
    output logic [DCACHE_INDEX_WIDTH-1:0] address_index_o,
    output logic [DCACHE_TAG_WIDTH-1:0]   address_tag_o,
    output logic                          tag_valid_o,
    output logic                          kill_req_o,
    output logic [7:0]                    data_be_o,
    output logic [1:0]                    data_size_o,
    input  logic                          data_rvalid_i,
    input  logic [XLEN-1:0]               data_rdata_i
);

    logic [2:0] ld_offset;
    load_op_e   op_q;
    logic [2:0] offset_q;
    load_word_u rdata;

    // the low 12 bits also feed the store checker through vaddr_o
    assign vaddr_o = vaddr_i;
    // byte position of the load inside the 64-bit word
    assign ld_offset = vaddr_i[2:0];
    // index goes out with the request, it needs no translation
    assign address_index_o = vaddr_i[DCACHE_INDEX_WIDTH-1:0];
    // the tag cycle follows the grant, when paddr_i still holds this load's translation
    assign address_tag_o = paddr_i[DCACHE_TAG_WIDTH+DCACHE_INDEX_WIDTH-1:DCACHE_INDEX_WIDTH];

    assign rdata.word = data_rdata_i;

    // --------------------
    // load control
    // --------------------
    load_ctrl_fsm u_ctrl (
        .clk_i                 (clk_i),
        .rst_ni                (rst_ni),
        .flush_i               (flush_i),
        .valid_i               (valid_i),
        .trans_id_i            (trans_id_i),
        .offset_i              (ld_offset),
        .op_i                  (op_i),
        .be_i                  (be_i),
        .pop_ld_o              (pop_ld_o),
        .page_offset_matches_i (page_offset_matches_i),
        .dtlb_hit_i            (dtlb_hit_i),
        .translation_req_o     (translation_req_o),
        .data_req_o            (data_req_o),
        .data_gnt_i            (data_gnt_i),
        .tag_valid_o           (tag_valid_o),
        .kill_req_o            (kill_req_o),
        .data_be_o             (data_be_o),
        .data_size_o           (data_size_o),
        .data_rvalid_i         (data_rvalid_i),
        .valid_o               (valid_o),
        .trans_id_o            (trans_id_o),
        .op_q_o                (op_q),
        .offset_q_o            (offset_q)
    );

    // --------------------
    // result alignment
    // --------------------
    load_result_align u_align (
        .clk_i      (clk_i),
        .rst_ni     (rst_ni),
        .pop_i      (pop_ld_o),
        .op_d_i     (op_i),
        .offset_d_i (ld_offset),
        .op_q_i     (op_q),
        .offset_q_i (offset_q),
        .rdata_i    (rdata),
        .valid_i    (valid_o),
        .result_o   (result_o)
    );

endmodule

// File: include/load_tb_tasks.svh
// --------------------
// load unit testbench helpers
// value check, bounded waits and the TLB and data-cache models
// that run inside the testbench module beside the DUT port signals
// --------------------

`ifndef LOAD_TB_TASKS_SVH
`define LOAD_TB_TASKS_SVH

// running totals for the closing summary
int unsigned n_checks;
int unsigned n_errors;

// compares one value and reports a mismatch with time and signal name
task automatic check_eq(input string name, input logic [63:0] got, input logic [63:0] exp);
    n_checks++;
    if (got !== exp) begin
        n_errors++;
        $display("FAILED at %0t: %s is %h, expected %h", $time, name, got, exp);
    end
endtask

// samples on falling edges where the current cycle's outputs are settled
// and gives up after 50 cycles
task automatic wait_tag(output bit seen);
    seen = 1'b0;
    for (int n = 0; n < 50; n++) begin
        @(negedge clk_i);
        if (tag_valid_o) begin
            seen = 1'b1;
            break;
        end
    end
    if (!seen) begin
        n_errors++;
        $display("no tag cycle came within 50 cycles");
    end
endtask

// TLB answers in the cycle of the request
task automatic tlb_answer(input logic hit, input logic [55:0] paddr);
    dtlb_hit_i = hit;
    paddr_i    = paddr;
endtask

// cache answers only a live tag and does so in the tag cycle itself
task automatic cache_answer(input logic [63:0] word);
    data_rdata_i  = word;
    data_rvalid_i = tag_valid_o && !kill_req_o;
endtask

`endif

// File: sim/tb_load_unit.sv
// --------------------
// load unit testbench
// directed loads through the TLB and data-cache models that cover
// alignment, grant delay, store hold-off, TLB miss and flush
// --------------------

`timescale 1ns/100ps

module tb_load_unit import load_pkg::*; ();

    logic                          clk_i, rst_ni, flush_i, valid_i;
    logic [TRANS_ID_BITS-1:0]      trans_id_i, trans_id_o;
    logic [VLEN-1:0]               vaddr_i, vaddr_o;
    load_op_e                      op_i;
    logic [7:0]                    be_i, data_be_o;
    logic                          pop_ld_o, valid_o, translation_req_o;
    logic                          dtlb_hit_i, page_offset_matches_i;
    logic [XLEN-1:0]               result_o, data_rdata_i;
    logic [PLEN-1:0]               paddr_i;
    logic                          data_req_o, data_gnt_i, tag_valid_o;
    logic                          kill_req_o, data_rvalid_i;
    logic [DCACHE_INDEX_WIDTH-1:0] address_index_o;
    logic [DCACHE_TAG_WIDTH-1:0]   address_tag_o;
    logic [1:0]                    data_size_o;

    // load currently issued and kept for the checks in its tag cycle
    logic [63:0]      cur_word;
    logic [PLEN-1:0]  cur_paddr;
    logic [2:0]       cur_off, cur_id;
    load_op_e         cur_op;

    load_unit u_load_unit (.*);

    `include "load_tb_tasks.svh"

    always #50 clk_i = ~clk_i;

    // log2 of the access width in bytes as the cache size code encodes it
    function automatic int size_log2(input load_op_e op);
        case (op)
            LD: return 3;
            LW, LWU: return 2;
            LH, LHU: return 1;
            default: return 0;
        endcase
    endfunction

    // drop the bytes below the offset, keep the access width, then extend
    function automatic logic [63:0] expected_result(input load_op_e op, input logic [2:0] off,
                                                    input logic [63:0] word);
        logic [63:0] s;
        s = word >> (8 * int'(off));
        case (op)
            LW: return {{32{s[31]}}, s[31:0]};
            LWU: return {32'd0, s[31:0]};
            LH: return {{48{s[15]}}, s[15:0]};
            LHU: return {48'd0, s[15:0]};
            LB: return {{56{s[7]}}, s[7:0]};
            LBU: return {56'd0, s[7:0]};
            default: return s;
        endcase
    endfunction

    // new word, addresses and id together with the byte enables of the access
    task automatic issue_load(input load_op_e op, input logic [2:0] off);
        int nbytes;
        nbytes       = 1 << size_log2(op);
        cur_op       = op;
        cur_off      = off;
        cur_id       = 3'($urandom);
        cur_word     = {$urandom, $urandom};
        cur_paddr    = {24'($urandom), $urandom};
        valid_i      = 1'b1;
        trans_id_i   = cur_id;
        vaddr_i      = {7'($urandom), $urandom};
        vaddr_i[2:0] = off;
        op_i         = op;
        be_i         = 8'(((1 << nbytes) - 1) << off);
        tlb_answer(1'b1, cur_paddr);
    endtask

    // any operation at an offset that keeps the access inside the word
    task automatic issue_random();
        load_op_e op;
        op = load_op_e'(4'($urandom_range(6, 0)));
        issue_load(op, 3'($urandom_range(8 - (1 << size_log2(op)), 0)));
    endtask

    // grant with a TLB hit pops the load in this very cycle
    task automatic grant_now();
        data_gnt_i = 1'b1;
        #10;
        check_eq("pop_ld_o", 64'(pop_ld_o), 64'd1);
        check_eq("data_req_o", 64'(data_req_o), 64'd1);
        check_eq("data_size_o", 64'(data_size_o), 64'(size_log2(cur_op)));
        check_eq("data_be_o", 64'(data_be_o), 64'(be_i));
        check_eq("address_index_o", 64'(address_index_o), 64'(vaddr_i[11:0]));
        check_eq("vaddr_o", 64'(vaddr_o), 64'(vaddr_i));
    endtask

    task automatic await_pop();
        bit seen;
        seen = 1'b0;
        for (int n = 0; n < 50 && !seen; n++) begin
            @(negedge clk_i);
            #10;
            seen = pop_ld_o;
        end
        if (!seen) begin
            n_errors++;
            $display("the load was never popped within 50 cycles");
        end
    endtask

    // the tag cycle after the pop is where the cache model returns the word
    task automatic complete_load();
        bit seen;
        wait_tag(seen);
        if (seen) begin
            valid_i    = 1'b0;
            data_gnt_i = 1'b0;
            cache_answer(cur_word);
            #10;
            check_eq("kill_req_o", 64'(kill_req_o), 64'd0);
            check_eq("valid_o", 64'(valid_o), 64'd1);
            check_eq("trans_id_o", 64'(trans_id_o), 64'(cur_id));
            check_eq("result_o", result_o, expected_result(cur_op, cur_off, cur_word));
            check_eq("address_tag_o", 64'(address_tag_o), 64'(cur_paddr[55:12]));
        end
        @(negedge clk_i);
        data_rvalid_i = 1'b0;
    endtask

    task automatic print_result(input string name, input int unsigned errs);
        $display("test %s: %s", name, (n_errors == errs) ? "ok" : "mismatches");
    endtask

    // --------------------
    // directed tests
    // --------------------
    task automatic aligned_ld();
        int unsigned errs;
        errs = n_errors;
        @(negedge clk_i);
        issue_load(LD, 3'd0);
        grant_now();
        complete_load();
        print_result("aligned_ld", errs);
    endtask

    task automatic sub_word_loads();
        int unsigned errs;
        errs = n_errors;
        repeat (40) begin
            @(negedge clk_i);
            issue_random();
            grant_now();
            complete_load();
        end
        print_result("sub_word_loads", errs);
    endtask

    // the request must stay up without a pop while the cache holds off
    task automatic delayed_grant();
        int unsigned errs;
        int          k;
        errs = n_errors;
        k    = int'($urandom_range(5, 1));
        @(negedge clk_i);
        issue_random();
        data_gnt_i = 1'b0;
        for (int i = 0; i < k; i++) begin
            if (i != 0) begin
                @(negedge clk_i);
            end
            #10;
            check_eq("data_req_o", 64'(data_req_o), 64'd1);
            check_eq("pop_ld_o", 64'(pop_ld_o), 64'd0);
        end
        @(negedge clk_i);
        grant_now();
        complete_load();
        print_result("delayed_grant", errs);
    endtask

    // a grant is offered all along but no request may go out during the match
    task automatic offset_hold();
        int unsigned errs;
        int          k;
        errs = n_errors;
        k    = int'($urandom_range(5, 1));
        @(negedge clk_i);
        issue_random();
        page_offset_matches_i = 1'b1;
        data_gnt_i            = 1'b1;
        for (int i = 0; i < k; i++) begin
            if (i != 0) begin
                @(negedge clk_i);
            end
            #10;
            check_eq("data_req_o", 64'(data_req_o), 64'd0);
            check_eq("pop_ld_o", 64'(pop_ld_o), 64'd0);
        end
        @(negedge clk_i);
        page_offset_matches_i = 1'b0;
        await_pop();
        complete_load();
        print_result("offset_hold", errs);
    endtask

    task automatic tlb_miss_retry();
        int unsigned errs;
        int          k;
        errs = n_errors;
        k    = int'($urandom_range(3, 1));
        @(negedge clk_i);
        issue_random();
        dtlb_hit_i = 1'b0;
        data_gnt_i = 1'b1;
        #10;
        check_eq("pop_ld_o", 64'(pop_ld_o), 64'd0);
        // a stray response in the abort cycle must not retire
        @(negedge clk_i);
        data_rvalid_i = 1'b1;
        #10;
        check_eq("kill_req_o", 64'(kill_req_o), 64'd1);
        check_eq("tag_valid_o", 64'(tag_valid_o), 64'd1);
        check_eq("valid_o", 64'(valid_o), 64'd0);
        check_eq("translation_req_o", 64'(translation_req_o), 64'd1);
        repeat (k) begin
            @(negedge clk_i);
            data_rvalid_i = 1'b0;
            #10;
            check_eq("translation_req_o", 64'(translation_req_o), 64'd1);
            check_eq("data_req_o", 64'(data_req_o), 64'd0);
        end
        @(negedge clk_i);
        dtlb_hit_i = 1'b1;
        await_pop();
        complete_load();
        print_result("tlb_miss_retry", errs);
    endtask

    task automatic flush_discard();
        int unsigned errs;
        errs = n_errors;
        @(negedge clk_i);
        issue_random();
        flush_i = 1'b1;
        grant_now();
        @(negedge clk_i);
        flush_i       = 1'b0;
        valid_i       = 1'b0;
        data_gnt_i    = 1'b0;
        data_rvalid_i = 1'b1;
        #10;
        check_eq("kill_req_o", 64'(kill_req_o), 64'd1);
        check_eq("valid_o", 64'(valid_o), 64'd0);
        @(negedge clk_i);
        data_rvalid_i = 1'b0;
        // the unit is back in IDLE and takes the next load at once
        issue_random();
        grant_now();
        complete_load();
        print_result("flush_discard", errs);
    endtask

    initial begin
        void'($urandom(81));
        clk_i                 = 1'b0;
        rst_ni                = 1'b0;
        flush_i               = 1'b0;
        valid_i               = 1'b0;
        trans_id_i            = '0;
        vaddr_i               = '0;
        op_i                  = LD;
        be_i                  = '0;
        paddr_i               = '0;
        dtlb_hit_i            = 1'b0;
        page_offset_matches_i = 1'b0;
        data_gnt_i            = 1'b0;
        data_rvalid_i         = 1'b0;
        data_rdata_i          = '0;
        repeat (5) @(negedge clk_i);
        rst_ni = 1'b1;
        #10;
        check_eq("pop_ld_o", 64'(pop_ld_o), 64'd0);
        check_eq("valid_o", 64'(valid_o), 64'd0);
        check_eq("data_req_o", 64'(data_req_o), 64'd0);
        check_eq("tag_valid_o", 64'(tag_valid_o), 64'd0);
        check_eq("kill_req_o", 64'(kill_req_o), 64'd0);
        check_eq("translation_req_o", 64'(translation_req_o), 64'd0);
        print_result("reset_state", 0);
        aligned_ld();
        sub_word_loads();
        delayed_grant();
        offset_hold();
        tlb_miss_retry();
        flush_discard();
        $display("checks %0d, errors %0d", n_checks, n_errors);
        if (n_errors == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// File: verilog.f
+incdir+include
hdl/load_pkg.sv
hdl/load_ctrl_fsm.sv
hdl/load_result_align.sv
hdl/load_unit.sv
sim/tb_load_unit.sv

// File: run_sim.sh
#!/usr/bin/env bash
# builds the load unit testbench with Verilator and runs it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f verilog.f --top-module tb_load_unit -Mdir obj_dir

output=$(./obj_dir/Vtb_load_unit)
echo "$output"

if echo "$output" | grep -q "^Test passed$"; then
    exit 0
fi
exit 1
